//--- project.f
hdl/fmb_tester_pkg.sv
hdl/burst_cmd_if.sv
hdl/sys_reset_gen.sv
hdl/ddr_reset_sequencer.sv
hdl/mem_test_sequencer.sv
hdl/axi_burst_engine.sv
hdl/status_led_driver.sv
hdl/fmb_tester_top.sv
bench/fmb_tester_chk.sv
bench/tb_fmb_tester.sv

//--- Bender.yml
package:
  name: fmb_tester

sources:
  - hdl/fmb_tester_pkg.sv
  - hdl/burst_cmd_if.sv
  - hdl/sys_reset_gen.sv
  - hdl/ddr_reset_sequencer.sv
  - hdl/mem_test_sequencer.sv
  - hdl/axi_burst_engine.sv
  - hdl/status_led_driver.sv
  - hdl/fmb_tester_top.sv
  - target: test
    files:
      - bench/fmb_tester_chk.sv
      - bench/tb_fmb_tester.sv

//--- bench/tb_fmb_tester.sv
`timescale 1ns/1ps
//------------------------------------------------------------
// DDR tester testbench
// AXI memory model with fault injection, pattern and LED checks
//------------------------------------------------------------
module tb_fmb_tester;
	import fmb_tester_pkg::*;

	localparam int CYCLE_LIMIT = 4 * (2 * 2 * TEST_BURSTS * 40) + 200;

	logic iSCLK = 1'b0;
	logic inPbSwX, bl1_lock, tl2_lock, cfg_done;
	logic o_cfg_reset, o_cfg_start, o_axi_nreset;
	logic o_awvalid, awready, o_wvalid, wready, o_wlast, bvalid, o_bready;
	logic o_arvalid, arready, rvalid, rlast, o_rready;
	logic [AXI_ADDR_W-1:0] o_awaddr, o_araddr;
	logic [AXI_DATA_W-1:0] o_wdata, rdata;
	logic [AXI_STRB_W-1:0] o_wstrb;
	logic [1:0] bresp, rresp;
	logic [7:2] o_led;

	// Run options and model state
	logic rand_mode, flip_mode, slverr_mode;
	logic [15:0] lfsr = 16'd15042;
	logic [AXI_DATA_W-1:0] mem [logic [AXI_ADDR_W-1:0]];
	int cycles = 0;
	// Checker counters
	int wr_bursts, rd_bursts, wbeat, led7_edges;
	logic [AXI_ADDR_W-1:0] wr_base;

	fmb_tester_top i_dut (
		.iSCLK(iSCLK), .inPbSwX(inPbSwX),
		.i_pll_bl1_locked(bl1_lock), .i_pll_tl2_locked(tl2_lock),
		.i_cfg_done(cfg_done), .o_cfg_reset(o_cfg_reset),
		.o_cfg_start(o_cfg_start), .o_axi_nreset(o_axi_nreset),
		.o_awvalid(o_awvalid), .i_awready(awready), .o_awaddr(o_awaddr),
		.o_wvalid(o_wvalid), .i_wready(wready), .o_wdata(o_wdata),
		.o_wstrb(o_wstrb), .o_wlast(o_wlast),
		.i_bvalid(bvalid), .i_bresp(bresp), .o_bready(o_bready),
		.o_arvalid(o_arvalid), .i_arready(arready), .o_araddr(o_araddr),
		.i_rvalid(rvalid), .i_rdata(rdata), .i_rresp(rresp), .i_rlast(rlast),
		.o_rready(o_rready), .o_led(o_led)
	);

	always #50 iSCLK = ~iSCLK;

	// Hung run guard
	always @(posedge iSCLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	// Galois LFSR stepped once per bit
	function automatic logic next_rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 16'hB400;
		return b;
	endfunction

	// Expected beat word with the lane number above the low 29 address bits
	function automatic logic [AXI_DATA_W-1:0] ref_beat(logic [AXI_ADDR_W-1:0] a, logic inv);
		logic [AXI_DATA_W-1:0] w;
		for (int l = 0; l < 8; l++)
			w[l*32 +: 32] = {l[2:0], a[28:0]};
		return inv ? ~w : w;
	endfunction

	// Bring-up state seen from the board pins
	function automatic ddr_cfg_state_t seen_state();
		if (o_cfg_reset)
			return CFG_RST;
		else if (o_cfg_start)
			return CFG_START;
		else if (o_axi_nreset)
			return READY;
		return HOLD;
	endfunction

	//------------------------------------------------------------
	task automatic stop_with_fail(string msg);
		$display("[FAIL] time %0d ns: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic check_data(logic [AXI_DATA_W-1:0] act, logic [AXI_DATA_W-1:0] exp,
		string what);
		if (act !== exp)
			stop_with_fail($sformatf("%s got %h expected %h", what, act, exp));
	endtask

	task automatic check_addr(logic [AXI_ADDR_W-1:0] act, logic [AXI_ADDR_W-1:0] exp,
		string what);
		if (act !== exp)
			stop_with_fail($sformatf("%s got %h expected %h", what, act, exp));
	endtask

	task automatic check_flag(logic act, logic exp, string what);
		if (act !== exp)
			stop_with_fail($sformatf("%s got %b expected %b", what, act, exp));
	endtask

	task automatic check_state(ddr_cfg_state_t exp);
		ddr_cfg_state_t act;
		act = seen_state();
		if (act !== exp)
			stop_with_fail($sformatf("bring-up state %s expected %s", act.name(), exp.name()));
	endtask

	//------------------------------------------------------------
	// AXI slave model
	// Samples at negedge and drives 5 ns after posedge
	initial
	begin
		logic aw_f, w_f, b_f, ar_f, r_f, wl, bpend, rbusy;
		logic [AXI_ADDR_W-1:0] waddr, raddr;
		logic [AXI_DATA_W-1:0] wd;
		int rcnt, wcnt, arcnt;
		forever
		begin
			@(negedge iSCLK);
			aw_f = o_awvalid & awready;
			w_f  = o_wvalid & wready;
			b_f  = bvalid & o_bready;
			ar_f = o_arvalid & arready;
			r_f  = rvalid & o_rready;
			wl   = o_wlast;
			wd   = o_wdata;
			if (aw_f)
				waddr = o_awaddr;
			if (ar_f)
				raddr = o_araddr;
			@(posedge iSCLK);
			#5;
			if (!inPbSwX)
			begin
				mem.delete();
				{awready, wready, arready, bvalid, rvalid, rlast} = '0;
				{bpend, rbusy} = '0;
				wcnt = 0;
				arcnt = 0;
			end
			else
			begin
				// Write side
				if (aw_f)
					wcnt++;
				if (w_f)
				begin
					mem[waddr] = wd;
					waddr += BEAT_BYTES;
					if (wl)
						bpend = 1'b1;
				end
				if (b_f)
					bvalid = 1'b0;
				if (bpend && !bvalid)
				begin
					bvalid = 1'b1;
					bpend  = 1'b0;
					// One SLVERR on the sixth write
					bresp  = (slverr_mode && wcnt == 6) ? 2'b10 : 2'b00;
				end
				// Read side
				if (ar_f)
				begin
					arcnt++;
					rbusy = 1'b1;
					rcnt  = 0;
				end
				if (r_f)
				begin
					raddr += BEAT_BYTES;
					rcnt++;
					if (rcnt == BURST_BEATS)
						rbusy = 1'b0;
				end
				rvalid = rbusy;
				rlast  = rbusy && (rcnt == BURST_BEATS - 1);
				rdata  = mem.exists(raddr) ? mem[raddr] : '0;
				// Single bit flip inside a pass 1 read
				if (flip_mode && arcnt == 21 && rcnt == 2)
					rdata[100] = ~rdata[100];
				awready = rand_mode ? next_rand_bit() : 1'b1;
				wready  = rand_mode ? next_rand_bit() : 1'b1;
				arready = rand_mode ? next_rand_bit() : 1'b1;
			end
		end
	end

	//------------------------------------------------------------
	// Write stream compare against the reference pattern
	initial
	begin
		logic led7_q;
		forever
		begin
			@(negedge iSCLK);
			if (i_dut.u_chk.fail_cnt != 0)
				stop_with_fail("a bound protocol assertion failed");
			if (!inPbSwX)
			begin
				{wr_bursts, rd_bursts, led7_edges, wbeat} = '0;
				led7_q = 1'b0;
			end
			else
			begin
				if (o_led[7] != led7_q)
					led7_edges++;
				led7_q = o_led[7];
				if (o_awvalid && awready)
				begin
					wr_base = AXI_ADDR_W'((wr_bursts % TEST_BURSTS) * BURST_BYTES);
					check_addr(o_awaddr, wr_base, "AWADDR");
					wr_bursts++;
					wbeat = 0;
				end
				if (o_arvalid && arready)
				begin
					check_addr(o_araddr,
						AXI_ADDR_W'((rd_bursts % TEST_BURSTS) * BURST_BYTES), "ARADDR");
					rd_bursts++;
				end
				if (o_wvalid && wready)
				begin
					check_data(o_wdata, ref_beat(wr_base + AXI_ADDR_W'(wbeat * BEAT_BYTES),
						wr_bursts > TEST_BURSTS), "WDATA");
					check_flag(&o_wstrb, 1'b1, "WSTRB all set");
					check_flag(o_wlast, wbeat == BURST_BEATS - 1, "WLAST");
					wbeat++;
				end
			end
		end
	end

	//------------------------------------------------------------
	task automatic idle_checks();
		check_state(HOLD);
		check_flag(o_awvalid | o_wvalid | o_arvalid, 1'b0, "valid while locks low");
		check_flag(o_bready | o_rready, 1'b0, "BREADY or RREADY while locks low");
		check_flag(o_led[4], 1'b0, "LED 4 before cfg_done");
		check_flag(|o_led[7:5], 1'b0, "LEDs 5 to 7 while locks low");
	endtask

	task automatic run_test(logic rnd, logic flp, logic slv, logic exp_fail);
		int n;
		rand_mode = rnd;
		flip_mode = flp;
		slverr_mode = slv;
		@(posedge iSCLK);
		#5;
		{inPbSwX, bl1_lock, tl2_lock, cfg_done} = '0;
		repeat (10) @(posedge iSCLK);
		#5;
		inPbSwX = 1'b1;
		repeat (3) @(negedge iSCLK);
		idle_checks();
		// One lock alone keeps reset held
		@(posedge iSCLK);
		#5;
		bl1_lock = 1'b1;
		repeat (4) @(negedge iSCLK);
		idle_checks();
		check_flag(o_led[2], 1'b1, "LED 2 follows lock");
		check_flag(o_led[3], 1'b0, "LED 3 follows lock");
		@(posedge iSCLK);
		#5;
		tl2_lock = 1'b1;
		// Config reset length
		while (!o_cfg_reset)
			@(negedge iSCLK);
		n = 0;
		while (o_cfg_reset)
		begin
			n++;
			@(negedge iSCLK);
		end
		check_flag(n == CFG_RST_CYCLES, 1'b1, "cfg_reset length");
		check_state(CFG_START);
		check_flag(o_axi_nreset, 1'b1, "axi_nreset with cfg_start");
		repeat (3) @(posedge iSCLK);
		#5;
		cfg_done = 1'b1;
		@(negedge iSCLK);
		check_state(CFG_START);
		@(negedge iSCLK);
		check_state(READY);
		check_flag(o_led[4], 1'b1, "LED 4 follows cfg_done");
		// Wait for the done LED
		while (!o_led[6])
			@(negedge iSCLK);
		@(negedge iSCLK);
		check_flag(o_led[5], exp_fail, "fail LED");
		check_flag(o_led[7], 1'b0, "run LED after done");
		check_flag(wr_bursts == 2 * TEST_BURSTS, 1'b1, "write burst count");
		check_flag(rd_bursts == 2 * TEST_BURSTS, 1'b1, "read burst count");
		if (rnd)
			check_flag(led7_edges >= 2, 1'b1, "run LED blink");
		check_flag(i_dut.u_chk.fail_cnt == 0, 1'b1, "protocol assertions clean");
	endtask

	initial
	begin
		{inPbSwX, bl1_lock, tl2_lock, cfg_done} = '0;
		{awready, wready, bvalid, arready, rvalid, rlast} = '0;
		bresp = 2'b00;
		rresp = 2'b00;
		rdata = '0;
		{rand_mode, flip_mode, slverr_mode} = '0;
		run_test(1'b0, 1'b0, 1'b0, 1'b0);
		run_test(1'b1, 1'b0, 1'b0, 1'b0);
		run_test(1'b0, 1'b1, 1'b0, 1'b1);
		run_test(1'b1, 1'b0, 1'b1, 1'b1);
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- bench/fmb_tester_chk.sv
`timescale 1ns/1ps
//------------------------------------------------------------
// Tester protocol checks
// AXI hold rules and controller bring-up order
//------------------------------------------------------------
module fmb_tester_chk (
	input logic                                  iSCLK,
	input logic                                  inPbSwX,
	input logic                                  i_awvalid,
	input logic                                  i_awready,
	input logic [fmb_tester_pkg::AXI_ADDR_W-1:0] i_awaddr,
	input logic                                  i_wvalid,
	input logic                                  i_wready,
	input logic [fmb_tester_pkg::AXI_DATA_W-1:0] i_wdata,
	input logic                                  i_cfg_reset,
	input logic                                  i_cfg_start,
	input logic                                  i_axi_nreset
);

	// Number of failed properties
	int fail_cnt = 0;

	// Address held while stalled
	a_aw_stable: assert property (@(posedge iSCLK) disable iff (!inPbSwX)
		i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
	else
	begin
		$error("AWADDR changed or AWVALID dropped before AWREADY");
		fail_cnt++;
	end

	// Data held while stalled
	a_w_stable: assert property (@(posedge iSCLK) disable iff (!inPbSwX)
		i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata))
	else
	begin
		$error("WDATA changed or WVALID dropped before WREADY");
		fail_cnt++;
	end

	a_cfg_order: assert property (@(posedge iSCLK) disable iff (!inPbSwX)
		!(i_cfg_start && i_cfg_reset))
	else
	begin
		$error("cfg_start high during cfg_reset");
		fail_cnt++;
	end

	// Controller AXI side must be out of reset first
	a_aw_nreset: assert property (@(posedge iSCLK) disable iff (!inPbSwX)
		i_awvalid |-> i_axi_nreset)
	else
	begin
		$error("AWVALID before axi_nreset");
		fail_cnt++;
	end

endmodule

// Watch the burst engine and the config sequencer ports
bind fmb_tester_top fmb_tester_chk u_chk (
	.iSCLK        (iSCLK),
	.inPbSwX      (inPbSwX),
	.i_awvalid    (u_axi_burst_engine.o_awvalid),
	.i_awready    (u_axi_burst_engine.i_awready),
	.i_awaddr     (u_axi_burst_engine.o_awaddr),
	.i_wvalid     (u_axi_burst_engine.o_wvalid),
	.i_wready     (u_axi_burst_engine.i_wready),
	.i_wdata      (u_axi_burst_engine.o_wdata),
	.i_cfg_reset  (u_ddr_reset_sequencer.o_cfg_reset),
	.i_cfg_start  (u_ddr_reset_sequencer.o_cfg_start),
	.i_axi_nreset (u_ddr_reset_sequencer.o_axi_nreset)
);

//--- hdl/fmb_tester_top.sv
`timescale 1ns/1ps
//------------------------------------------------------------
// DDR memory tester top level
// Reset, controller config, AXI pattern test and status LEDs
//------------------------------------------------------------
module fmb_tester_top (
	input  logic                                    iSCLK,
	input  logic                                    inPbSwX,
	input  logic                                    i_pll_bl1_locked,
	input  logic                                    i_pll_tl2_locked,
	// Controller configuration
	input  logic                                    i_cfg_done,
	output logic                                    o_cfg_reset,
	output logic                                    o_cfg_start,
	output logic                                    o_axi_nreset,
	// AXI4 master port
	output logic                                    o_awvalid,
	input  logic                                    i_awready,
	output logic [fmb_tester_pkg::AXI_ADDR_W-1:0]   o_awaddr,
	output logic                                    o_wvalid,
	input  logic                                    i_wready,
	output logic [fmb_tester_pkg::AXI_DATA_W-1:0]   o_wdata,
	output logic [fmb_tester_pkg::AXI_STRB_W-1:0]   o_wstrb,
	output logic                                    o_wlast,
	input  logic                                    i_bvalid,
	input  logic [1:0]                              i_bresp,
	output logic                                    o_bready,
	output logic                                    o_arvalid,
	input  logic                                    i_arready,
	output logic [fmb_tester_pkg::AXI_ADDR_W-1:0]   o_araddr,
	input  logic                                    i_rvalid,
	input  logic [fmb_tester_pkg::AXI_DATA_W-1:0]   i_rdata,
	input  logic [1:0]                              i_rresp,
	input  logic                                    i_rlast,
	output logic                                    o_rready,
	// User LEDs
	output logic [7:2]                              o_led
);

	logic srst_n;
	logic cfg_ready;
	logic test_run;
	logic test_done;
	logic test_fail;

	// Sequencer to engine
	burst_cmd_if cmd_bus ();

	//--------------------------------------------------------
	// Reset and controller bring-up
	sys_reset_gen u_sys_reset_gen (
		.iSCLK            (iSCLK),
		.inPbSwX          (inPbSwX),
		.i_pll_bl1_locked (i_pll_bl1_locked),
		.i_pll_tl2_locked (i_pll_tl2_locked),
		.o_srst_n         (srst_n)
	);

	ddr_reset_sequencer u_ddr_reset_sequencer (
		.iSCLK        (iSCLK),
		.inPbSwX      (inPbSwX),
		.i_srst_n     (srst_n),
		.i_cfg_done   (i_cfg_done),
		.o_cfg_reset  (o_cfg_reset),
		.o_cfg_start  (o_cfg_start),
		.o_axi_nreset (o_axi_nreset),
		.o_ready      (cfg_ready)
	);

	//--------------------------------------------------------
	// Pattern test
	mem_test_sequencer u_mem_test_sequencer (
		.iSCLK       (iSCLK),
		.inPbSwX     (inPbSwX),
		.i_ready     (cfg_ready),
		.o_cmd       (cmd_bus.seq),
		.o_test_run  (test_run),
		.o_test_done (test_done),
		.o_test_fail (test_fail)
	);

	axi_burst_engine u_axi_burst_engine (
		.iSCLK     (iSCLK),
		.inPbSwX   (inPbSwX),
		.i_cmd     (cmd_bus.eng),
		.o_awvalid (o_awvalid),
		.i_awready (i_awready),
		.o_awaddr  (o_awaddr),
		.o_wvalid  (o_wvalid),
		.i_wready  (i_wready),
		.o_wdata   (o_wdata),
		.o_wstrb   (o_wstrb),
		.o_wlast   (o_wlast),
		.i_bvalid  (i_bvalid),
		.i_bresp   (i_bresp),
		.o_bready  (o_bready),
		.o_arvalid (o_arvalid),
		.i_arready (i_arready),
		.o_araddr  (o_araddr),
		.i_rvalid  (i_rvalid),
		.i_rdata   (i_rdata),
		.i_rresp   (i_rresp),
		.i_rlast   (i_rlast),
		.o_rready  (o_rready)
	);

	//--------------------------------------------------------
	// Board LEDs
	status_led_driver u_status_led_driver (
		.iSCLK            (iSCLK),
		.inPbSwX          (inPbSwX),
		.i_pll_bl1_locked (i_pll_bl1_locked),
		.i_pll_tl2_locked (i_pll_tl2_locked),
		.i_cfg_done       (i_cfg_done),
		.i_test_run       (test_run),
		.i_test_done      (test_done),
		.i_test_fail      (test_fail),
		.o_led            (o_led)
	);

endmodule

//--- hdl/status_led_driver.sv
`timescale 1ns/1ps
//------------------------------------------------------------
// Status LED driver
// Registered lock, config and test status, blinking run LED
//------------------------------------------------------------
module status_led_driver (
	input  logic       iSCLK,
	input  logic       inPbSwX,
	input  logic       i_pll_bl1_locked,
	input  logic       i_pll_tl2_locked,
	input  logic       i_cfg_done,
	input  logic       i_test_run,
	input  logic       i_test_done,
	input  logic       i_test_fail,
	output logic [7:2] o_led
);
	import fmb_tester_pkg::*;

	// Blink divider, runs only while the test is active
	logic [BLINK_BITS-1:0] blink;

	always_ff @(posedge iSCLK or negedge inPbSwX)
	begin
		if (!inPbSwX)
		begin
			blink <= '0;
			o_led <= '0;
		end
		else
		begin
			if (i_test_run)
				blink <= blink + 1'b1;
			else
				blink <= '0;
			o_led[2] <= i_pll_bl1_locked;
			o_led[3] <= i_pll_tl2_locked;
			o_led[4] <= i_cfg_done;
			o_led[5] <= i_test_fail;
			o_led[6] <= i_test_done;
			// Run LED dark outside the test
			o_led[7] <= i_test_run & blink[BLINK_BITS-1];
		end
	end

endmodule

//--- hdl/axi_burst_engine.sv
`timescale 1ns/1ps
//------------------------------------------------------------
// AXI burst engine
// Runs one write or read burst and checks the read data
//------------------------------------------------------------
module axi_burst_engine (
	input  logic                                    iSCLK,
	input  logic                                    inPbSwX,
	burst_cmd_if.eng                                i_cmd,
	// Write address
	output logic                                    o_awvalid,
	input  logic                                    i_awready,
	output logic [fmb_tester_pkg::AXI_ADDR_W-1:0]   o_awaddr,
	// Write data
	output logic                                    o_wvalid,
	input  logic                                    i_wready,
	output logic [fmb_tester_pkg::AXI_DATA_W-1:0]   o_wdata,
	output logic [fmb_tester_pkg::AXI_STRB_W-1:0]   o_wstrb,
	output logic                                    o_wlast,
	// Write response
	input  logic                                    i_bvalid,
	input  logic [1:0]                              i_bresp,
	output logic                                    o_bready,
	// Read address
	output logic                                    o_arvalid,
	input  logic                                    i_arready,
	output logic [fmb_tester_pkg::AXI_ADDR_W-1:0]   o_araddr,
	// Read data
	input  logic                                    i_rvalid,
	input  logic [fmb_tester_pkg::AXI_DATA_W-1:0]   i_rdata,
	input  logic [1:0]                              i_rresp,
	input  logic                                    i_rlast,
	output logic                                    o_rready
);
	import fmb_tester_pkg::*;

	eng_state_t state;
	// Current beat address, burst base while an address is out
	logic [AXI_ADDR_W-1:0] addr_q;
	logic [BEAT_IDX_W-1:0] beat;
	test_pass_t            pass_q;
	logic                  bad;
	logic                  done;
	logic                  last_beat;
	logic                  beat_err;

	assign last_beat = (beat == BEAT_IDX_W'(BURST_BEATS - 1));

	// Read beat check
	// Data, response, and RLAST only on the final beat
	assign beat_err = (i_rdata != pattern_beat(addr_q, pass_q)) ||
		(i_rresp != RESP_OKAY) || (i_rlast != last_beat);

	always_ff @(posedge iSCLK or negedge inPbSwX)
	begin
		if (!inPbSwX)
		begin
			state     <= ENG_IDLE;
			o_awvalid <= 1'b0;
			o_wvalid  <= 1'b0;
			o_wlast   <= 1'b0;
			o_bready  <= 1'b0;
			o_arvalid <= 1'b0;
			o_rready  <= 1'b0;
			beat      <= '0;
			pass_q    <= PASS_PLAIN;
			bad       <= 1'b0;
			done      <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
			//----------------------------------------------------
			// Latch the command, raise the address valid
			ENG_IDLE:
				if (i_cmd.start)
				begin
					pass_q <= i_cmd.pass;
					bad    <= 1'b0;
					beat   <= '0;
					if (i_cmd.wr)
					begin
						o_awvalid <= 1'b1;
						state     <= ENG_AW;
					end
					else
					begin
						o_arvalid <= 1'b1;
						state     <= ENG_AR;
					end
				end
			//----------------------------------------------------
			// Write path
			ENG_AW:
				if (i_awready)
				begin
					o_awvalid <= 1'b0;
					o_wvalid  <= 1'b1;
					o_wlast   <= (BURST_BEATS == 1);
					state     <= ENG_W;
				end
			ENG_W:
				if (i_wready)
				begin
					if (o_wlast)
					begin
						o_wvalid <= 1'b0;
						o_wlast  <= 1'b0;
						o_bready <= 1'b1;
						state    <= ENG_B;
					end
					else
					begin
						beat    <= beat + 1'b1;
						o_wlast <= (beat == BEAT_IDX_W'(BURST_BEATS - 2));
					end
				end
			// Response ends the write burst
			ENG_B:
				if (i_bvalid)
				begin
					o_bready <= 1'b0;
					bad      <= bad | (i_bresp != RESP_OKAY);
					done     <= 1'b1;
					state    <= ENG_IDLE;
				end
			//----------------------------------------------------
			// Read path
			ENG_AR:
				if (i_arready)
				begin
					o_arvalid <= 1'b0;
					o_rready  <= 1'b1;
					state     <= ENG_R;
				end
			ENG_R:
				if (i_rvalid)
				begin
					bad  <= bad | beat_err;
					beat <= beat + 1'b1;
					if (last_beat)
					begin
						o_rready <= 1'b0;
						done     <= 1'b1;
						state    <= ENG_IDLE;
					end
				end
			default:
				state <= ENG_IDLE;
			endcase
		end
	end

	// Beat address follows accepted beats, held while waiting
	always_ff @(posedge iSCLK)
	begin
		if (state == ENG_IDLE && i_cmd.start)
			addr_q <= i_cmd.addr;
		else if ((state == ENG_AW && i_awready) || (state == ENG_W && i_wready) ||
			(state == ENG_R && i_rvalid))
			addr_q <= addr_q + AXI_ADDR_W'(BEAT_BYTES);
	end

	// Write data tracks the beat address
	always_ff @(posedge iSCLK)
	begin
		if ((state == ENG_AW && i_awready) || (state == ENG_W && i_wready && !o_wlast))
			o_wdata <= pattern_beat(addr_q, pass_q);
	end

	// Base address is steady for the whole address phase
	assign o_awaddr = addr_q;
	assign o_araddr = addr_q;
	// Full-width writes only
	assign o_wstrb  = {AXI_STRB_W{1'b1}};

	assign i_cmd.done = done;
	assign i_cmd.bad  = bad;

endmodule

//--- hdl/mem_test_sequencer.sv
`timescale 1ns/1ps
//------------------------------------------------------------
// Memory test sequencer
// Walks passes and bursts, issues commands, keeps the verdict
//------------------------------------------------------------
module mem_test_sequencer (
	input  logic       iSCLK,
	input  logic       inPbSwX,
	input  logic       i_ready,
	burst_cmd_if.seq   o_cmd,
	output logic       o_test_run,
	output logic       o_test_done,
	output logic       o_test_fail
);
	import fmb_tester_pkg::*;

	seq_state_t state;
	// Burst index within a pass
	logic [BURST_IDX_W-1:0] idx;
	logic       start;
	logic       wr;
	test_pass_t pass;
	logic       last_burst;

	assign last_burst = (idx == BURST_IDX_W'(TEST_BURSTS - 1));

	always_ff @(posedge iSCLK or negedge inPbSwX)
	begin
		if (!inPbSwX)
		begin
			state       <= SEQ_IDLE;
			idx         <= '0;
			start       <= 1'b0;
			wr          <= 1'b0;
			pass        <= PASS_PLAIN;
			o_test_run  <= 1'b0;
			o_test_done <= 1'b0;
			o_test_fail <= 1'b0;
		end
		else
		begin
			// Start is a pulse
			start <= 1'b0;
			// Sticky fail from any bad burst
			if (o_cmd.done && o_cmd.bad)
				o_test_fail <= 1'b1;

			case (state)
			//----------------------------------------------------
			// First write of pass 0
			SEQ_IDLE:
				if (i_ready)
				begin
					idx        <= '0;
					wr         <= 1'b1;
					pass       <= PASS_PLAIN;
					start      <= 1'b1;
					o_test_run <= 1'b1;
					state      <= SEQ_WRITE;
				end
			//----------------------------------------------------
			// Write all bursts, then turn to reads
			SEQ_WRITE:
				if (o_cmd.done)
				begin
					start <= 1'b1;
					if (last_burst)
					begin
						idx   <= '0;
						wr    <= 1'b0;
						state <= SEQ_READ;
					end
					else
						idx <= idx + 1'b1;
				end
			//----------------------------------------------------
			// Read back all bursts
			SEQ_READ:
				if (o_cmd.done)
				begin
					if (!last_burst)
					begin
						idx   <= idx + 1'b1;
						start <= 1'b1;
					end
					else if (pass == PASS_PLAIN)
						state <= SEQ_NEXT;
					else
					begin
						// End of pass 1
						o_test_run  <= 1'b0;
						o_test_done <= 1'b1;
						state       <= SEQ_DONE;
					end
				end
			// Inverted pass from address 0
			SEQ_NEXT:
			begin
				idx   <= '0;
				wr    <= 1'b1;
				pass  <= PASS_INVERT;
				start <= 1'b1;
				state <= SEQ_WRITE;
			end
			// Done holds until reset
			default:
				state <= SEQ_DONE;
			endcase
		end
	end

	// Burst base from the index
	assign o_cmd.start = start;
	assign o_cmd.wr    = wr;
	assign o_cmd.pass  = pass;
	assign o_cmd.addr  = AXI_ADDR_W'(idx) * AXI_ADDR_W'(BURST_BYTES);

endmodule

//--- hdl/ddr_reset_sequencer.sv
`timescale 1ns/1ps
//------------------------------------------------------------
// Controller configuration sequencer
// Steps config reset, config start and AXI reset release
//------------------------------------------------------------
module ddr_reset_sequencer (
	input  logic iSCLK,
	input  logic inPbSwX,
	input  logic i_srst_n,
	input  logic i_cfg_done,
	output logic o_cfg_reset,
	output logic o_cfg_start,
	output logic o_axi_nreset,
	output logic o_ready
);
	import fmb_tester_pkg::*;

	ddr_cfg_state_t state;
	// Counts cycles of the config reset
	logic [CFG_CNT_W-1:0] cnt;

	always_ff @(posedge iSCLK or negedge inPbSwX)
	begin
		if (!inPbSwX)
		begin
			state        <= HOLD;
			cnt          <= '0;
			o_cfg_reset  <= 1'b0;
			o_cfg_start  <= 1'b0;
			o_axi_nreset <= 1'b0;
		end
		else
		begin
			case (state)
			//----------------------------------------------------
			// Wait for system reset release
			HOLD:
				if (i_srst_n)
				begin
					o_cfg_reset <= 1'b1;
					cnt         <= '0;
					state       <= CFG_RST;
				end
			//----------------------------------------------------
			// Config reset, fixed length
			CFG_RST:
				if (cnt == CFG_CNT_W'(CFG_RST_CYCLES - 1))
				begin
					o_cfg_reset  <= 1'b0;
					o_cfg_start  <= 1'b1;
					// AXI side leaves reset with start
					o_axi_nreset <= 1'b1;
					state        <= CFG_START;
				end
				else
					cnt <= cnt + 1'b1;
			//----------------------------------------------------
			// Start held until the controller reports done
			CFG_START:
				if (i_cfg_done)
				begin
					o_cfg_start <= 1'b0;
					state       <= READY;
				end
			// Ready stays until the button
			default:
				state <= READY;
			endcase
		end
	end

	// Kicks off the test sequencer
	assign o_ready = (state == READY);

endmodule

//--- hdl/sys_reset_gen.sv
`timescale 1ns/1ps
//------------------------------------------------------------
// System reset generator
// Holds reset until both PLLs lock, then releases it for good
//------------------------------------------------------------
module sys_reset_gen (
	input  logic iSCLK,
	input  logic inPbSwX,
	input  logic i_pll_bl1_locked,
	input  logic i_pll_tl2_locked,
	output logic o_srst_n
);

	// Two-stage lock synchronizer
	logic lock_meta;
	logic lock_sync;

	always_ff @(posedge iSCLK or negedge inPbSwX)
	begin
		if (!inPbSwX)
		begin
			lock_meta <= 1'b0;
			lock_sync <= 1'b0;
			o_srst_n  <= 1'b0;
		end
		else
		begin
			// Both locks needed
			lock_meta <= i_pll_bl1_locked & i_pll_tl2_locked;
			lock_sync <= lock_meta;
			// Release once, only the button brings reset back
			if (lock_sync)
				o_srst_n <= 1'b1;
		end
	end

endmodule

//--- hdl/burst_cmd_if.sv
`timescale 1ns/1ps
//------------------------------------------------------------
// Burst command link
// Carries one burst request to the AXI engine and its verdict back
//------------------------------------------------------------
interface burst_cmd_if;
	import fmb_tester_pkg::*;

	// Request side, start is a single-cycle pulse
	logic                  start;
	logic                  wr;
	logic [AXI_ADDR_W-1:0] addr;
	test_pass_t            pass;

	// Completion side, bad is valid with the done pulse
	logic                  done;
	logic                  bad;

	// Test sequencer end
	modport seq (
		output start,
		output wr,
		output addr,
		output pass,
		input  done,
		input  bad
	);

	// Burst engine end
	modport eng (
		input  start,
		input  wr,
		input  addr,
		input  pass,
		output done,
		output bad
	);

endinterface

//--- hdl/fmb_tester_pkg.sv
//------------------------------------------------------------
// DDR tester shared definitions
// Test geometry, timing constants, state enums and pattern rule
//------------------------------------------------------------
package fmb_tester_pkg;

	// AXI geometry, bit 32 of the address is the chip select
	localparam int AXI_ADDR_W = 33;
	localparam int AXI_DATA_W = 256;
	localparam int AXI_STRB_W = 32;
	localparam int BEAT_BYTES = AXI_DATA_W / 8;

	// Burst shape
	localparam int BURST_BEATS = 4;
	localparam int BURST_BYTES = BURST_BEATS * BEAT_BYTES;
	localparam int BEAT_IDX_W = $clog2(BURST_BEATS);

	// Test region from address 0
	localparam int TEST_BURSTS = 16;
	localparam int BURST_IDX_W = $clog2(TEST_BURSTS);

	// Controller configuration reset length
	localparam int CFG_RST_CYCLES = 16;
	localparam int CFG_CNT_W = $clog2(CFG_RST_CYCLES);

	// Kept short so the blink shows up in simulation
	localparam int BLINK_BITS = 4;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef enum logic {PASS_PLAIN, PASS_INVERT} test_pass_t;

	typedef enum logic [2:0] {SEQ_IDLE, SEQ_WRITE, SEQ_READ, SEQ_NEXT, SEQ_DONE} seq_state_t;

	typedef enum logic [2:0] {ENG_IDLE, ENG_AW, ENG_W, ENG_B, ENG_AR, ENG_R} eng_state_t;

	typedef enum logic [1:0] {HOLD, CFG_RST, CFG_START, READY} ddr_cfg_state_t;

	// Expected beat word
	// Lane index on top, beat address in the low 29 bits of each lane
	function automatic logic [AXI_DATA_W-1:0] pattern_beat(
		input logic [AXI_ADDR_W-1:0] addr,
		input test_pass_t pass
	);
		logic [AXI_DATA_W-1:0] word;
		for (int i = 0; i < AXI_DATA_W / 32; i++)
		begin
			word[i*32 +: 32] = {3'(i), addr[28:0]};
		end
		// Second pass flips every bit
		if (pass == PASS_INVERT)
			word = ~word;
		return word;
	endfunction

endpackage
